// ==== sources.f ====
+incdir+.
cpu_bus_pkg.sv
icd_pkg.sv
trace_buf_if.sv
icd_byte_if.sv
cpu_phaser.sv
bus_trace_sampler.sv
trace_fifo.sv
icd_spi_slave.sv
icd_trace_reader.sv
nora_trace_top.sv
tb_nora_trace.sv

// ==== Makefile ====
# verilator build and run of the trace testbench
TOP := tb_nora_trace

.PHONY: compile run clean

compile:
	verilator --binary --timing -f sources.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// ==== tb_icd_tasks.svh ====
// spi master, icd command and compare tasks, included in the testbench top
// spi mode 0, msb first; uses SPI_HALF, seed and the pin signals of the top

task automatic step_clks(input int cycles);
    repeat (cycles) @(posedge clk6x);
    #1;     // inputs move just after the edge
endtask

task automatic check_byte(input string name, input cpu_data_t got, input cpu_data_t exp);
    if (got !== exp)
        report_failure($sformatf("error: %s got 0x%02h expected 0x%02h", name, got, exp));
endtask

task automatic check_rec(input string name, input trace_rec_t got, input trace_rec_t exp);
    if (got !== exp)
        report_failure($sformatf("error: %s got 0x%08h expected 0x%08h", name, got, exp));
endtask

task automatic check_status(input string name, input icd_status_t got,
                            input icd_status_t exp);
    if (got !== exp)
        report_failure($sformatf("error: %s got 0x%02h expected 0x%02h", name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
        report_failure($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
        report_failure($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

// one byte each way, miso sampled as sck rises
task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
    logic [7:0] out_sr;
    logic [7:0] in_sr;
    out_sr = tx;
    in_sr  = '0;
    repeat (8)
    begin
        mosi = out_sr[7];
        step_clks(SPI_HALF);
        in_sr  = {in_sr[6:0], miso};
        sck    = 1'b1;
        step_clks(SPI_HALF);
        sck    = 1'b0;
        out_sr = {out_sr[6:0], 1'b0};
    end
    rx = in_sr;
endtask

task automatic frame_begin();
    csn = 1'b0;
    step_clks(SPI_HALF);
    check_bit("icd_miso_oe_o", miso_oe, 1'b1);     // driven inside the frame
endtask

task automatic frame_end();
    step_clks(SPI_HALF);
    csn = 1'b1;
    step_clks(SPI_HALF + ($random(seed) & 7));    // random idle gap
    check_bit("icd_miso_oe_o", miso_oe, 1'b0);
endtask

task automatic read_status(output icd_status_t st);
    logic [7:0] rx;
    frame_begin();
    spi_xfer(CMD_STATUS, rx);
    check_byte("status header reply", rx, IDLE_BYTE);
    spi_xfer(IDLE_BYTE, rx);
    st = icd_status_t'(rx);
    spi_xfer(IDLE_BYTE, rx);        // surplus byte
    check_byte("status surplus reply", rx, IDLE_BYTE);
    frame_end();
endtask

task automatic write_control(input logic run, input logic trace, input logic clr_ovf);
    logic [7:0] flags;
    logic [7:0] rx;
    flags                   = '0;
    flags[CTRL_RUN_BIT]     = run;
    flags[CTRL_TRACE_BIT]   = trace;
    flags[CTRL_CLR_OVF_BIT] = clr_ovf;
    frame_begin();
    spi_xfer(CMD_CONTROL, rx);
    check_byte("control header reply", rx, IDLE_BYTE);
    spi_xfer(flags, rx);
    check_byte("control flag reply", rx, IDLE_BYTE);
    frame_end();
endtask

// header then the record msb first, all idle when the buffer is empty
task automatic read_record(output trace_rec_t rec);
    logic [7:0]             rx;
    logic [REC_BYTES*8-1:0] bytes;
    bytes = '0;
    frame_begin();
    spi_xfer(CMD_READ_TRACE, rx);
    check_byte("trace header reply", rx, IDLE_BYTE);
    repeat (REC_BYTES)
    begin
        spi_xfer(IDLE_BYTE, rx);
        bytes = {bytes[REC_BYTES*8-9:0], rx};
    end
    frame_end();
    rec = trace_rec_t'(bytes);
endtask

// ==== tb_nora_trace.sv ====
`timescale 1ns/1ps
// directed testbench for the trace path with icd spi at 8 clk6x per half period
// the cpu bus model steps its cycle count at each cphi2 fall
module tb_nora_trace;
    import cpu_bus_pkg::*;
    import icd_pkg::*;

    localparam int CLK_NS      = 4;
    localparam int SPI_HALF    = 8;                 // clk6x per sck half period
    localparam int BYTE_CLKS   = 16 * SPI_HALF;     // 8 bits of two halves each
    localparam int FRAME_CLKS  = 4 * SPI_HALF;      // csn setup, hold and gap
    localparam int TEST_BYTES  = 130;               // spi bytes over all tests
    localparam int TEST_FRAMES = 40;
    localparam int TRACE_CLKS  = 600;               // trace windows and cphi2 watches
    localparam int WATCHDOG_NS = 2 * CLK_NS *
        (TEST_BYTES * BYTE_CLKS + TEST_FRAMES * FRAME_CLKS + TRACE_CLKS);

    localparam logic [7:0] CMD_UNKNOWN = 8'h55;     // not in the command set

    logic        clk6x;
    logic        reset_i;
    cpu_addr_t   cpu_ab;
    cpu_data_t   cpu_db;
    cpu_status_t cpu_status;
    logic        sck;
    logic        csn;
    logic        mosi;
    wire         cphi2;
    wire         miso;
    wire         miso_oe;
    cpu_addr_t   bus_n;         // cpu cycle counter of the bus model
    integer      seed = 24;

    nora_trace_top i_nora_trace_top (
        .clk6x         (clk6x),
        .reset_i       (reset_i),
        .cpu_ab_i      (cpu_ab),
        .cpu_db_i      (cpu_db),
        .cpu_status_i  (cpu_status),
        .icd_sck_i     (sck),
        .icd_csn_i     (csn),
        .icd_mosi_i    (mosi),
        .cphi2_o       (cphi2),
        .icd_miso_o    (miso),
        .icd_miso_oe_o (miso_oe)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    `include "tb_icd_tasks.svh"

    // bus model rule with the cycle count as address
    function automatic trace_rec_t model_rec(input cpu_addr_t addr);
        trace_rec_t r;
        r.addr   = addr;
        r.data   = addr[7:0] ^ 8'hA5;
        r.status = cpu_status_t'(~addr[7:0]);
        return r;
    endfunction

    function automatic icd_status_t expect_status(input logic ovf, input level_t level);
        icd_status_t s;
        s.overflow = ovf;
        s.empty    = (level == '0);
        s.full     = (level == level_t'(TRACE_DEPTH));
        s.zero     = 1'b0;
        s.level    = level;
        return s;
    endfunction

    initial
    begin
        clk6x = 1'b0;
        forever #(CLK_NS / 2) clk6x = ~clk6x;
    end

    initial
    begin : cpu_bus_model
        trace_rec_t r;
        bus_n = '0;
        r = model_rec(bus_n);
        cpu_ab     = r.addr;
        cpu_db     = r.data;
        cpu_status = r.status;
        forever
        begin
            @(negedge cphi2);
            #1;
            bus_n      = bus_n + 16'd1;     // next cpu cycle
            r          = model_rec(bus_n);
            cpu_ab     = r.addr;
            cpu_db     = r.data;
            cpu_status = r.status;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the tests finished");
    end

    // drains count records that must follow each other
    task automatic read_records(input int count);
        trace_rec_t rec;
        cpu_addr_t  prev;
        prev = '0;
        for (int i = 0; i < count; i++)
        begin
            read_record(rec);
            if (i == 0)
                prev = rec.addr - 16'd1;    // first one only checked for consistency
            check_rec("trace record", rec, model_rec(prev + 16'd1));
            prev = rec.addr;
        end
    endtask

    task automatic clear_overflow_to_empty();
        icd_status_t st;
        write_control(1'b0, 1'b0, 1'b1);
        read_status(st);
        check_status("status after clear", st, expect_status(1'b0, '0));
    endtask

    task automatic after_reset();
        icd_status_t st;
        check_bit("icd_miso_oe_o", miso_oe, 1'b0);
        repeat (4 * PHASE_COUNT)
        begin
            check_bit("cphi2_o", cphi2, 1'b0);     // cpu held stopped
            step_clks(1);
        end
        read_status(st);
        check_status("status after reset", st, expect_status(1'b0, '0));
    endtask

    task automatic cpu_clock_shape();
        int cnt;
        write_control(1'b1, 1'b0, 1'b0);
        @(posedge cphi2);
        #1;
        repeat (3)
        begin
            cnt = 0;
            while (cphi2 === 1'b1)
            begin
                cnt++;
                step_clks(1);
            end
            check_count("cphi2_o high cycles", cnt, PHASE_COUNT / 2);
            cnt = 0;
            while (cphi2 === 1'b0)
            begin
                cnt++;
                step_clks(1);
            end
            check_count("cphi2_o low cycles", cnt, PHASE_COUNT / 2);
        end
        write_control(1'b0, 1'b0, 1'b0);
        repeat (4 * PHASE_COUNT)
        begin
            check_bit("cphi2_o", cphi2, 1'b0);
            step_clks(1);
        end
    endtask

    task automatic short_trace();
        icd_status_t st;
        write_control(1'b1, 1'b1, 1'b0);
        step_clks(2 * PHASE_COUNT);
        write_control(1'b0, 1'b0, 1'b0);
        read_status(st);
        if (st.level == '0 || st.level > level_t'(TRACE_DEPTH))
            report_failure($sformatf("error: status level 0x%0h outside 0x1 to 0x%0h",
                                     st.level, TRACE_DEPTH));
        read_records(int'(st.level));
        clear_overflow_to_empty();
    endtask

    task automatic overflow_trace();
        icd_status_t st;
        write_control(1'b1, 1'b1, 1'b0);
        step_clks(4 * TRACE_DEPTH * PHASE_COUNT);   // far past a full buffer
        write_control(1'b0, 1'b0, 1'b0);
        read_status(st);
        check_status("status after long trace", st,
                     expect_status(1'b1, level_t'(TRACE_DEPTH)));
        read_records(TRACE_DEPTH);
        clear_overflow_to_empty();
    endtask

    task automatic idle_replies();
        trace_rec_t  rec;
        icd_status_t st;
        logic [7:0]  rx;
        read_record(rec);
        check_rec("empty trace read", rec, trace_rec_t'({REC_BYTES{IDLE_BYTE}}));
        read_status(st);
        check_status("status after empty read", st, expect_status(1'b0, '0));
        frame_begin();
        spi_xfer(CMD_UNKNOWN, rx);
        check_byte("unknown header reply", rx, IDLE_BYTE);
        repeat (2)
        begin
            spi_xfer(8'h00, rx);
            check_byte("unknown surplus reply", rx, IDLE_BYTE);
        end
        frame_end();
    endtask

    initial
    begin
        reset_i = 1'b1;
        sck     = 1'b0;
        csn     = 1'b1;
        mosi    = 1'b0;
        repeat (5) @(posedge clk6x);
        #1;
        reset_i = 1'b0;
        step_clks(2);
        after_reset();
        cpu_clock_shape();
        short_trace();
        overflow_trace();
        idle_replies();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== nora_trace_top.sv ====
`timescale 1ns/1ps
// trace path of the glue fpga, clk6x is the only clock
// icd_miso_o is meaningful only while icd_miso_oe_o is high
module nora_trace_top (
    input  logic                     clk6x,
    input  logic                     reset_i,
    input  cpu_bus_pkg::cpu_addr_t   cpu_ab_i,
    input  cpu_bus_pkg::cpu_data_t   cpu_db_i,
    input  cpu_bus_pkg::cpu_status_t cpu_status_i,
    input  logic                     icd_sck_i,
    input  logic                     icd_csn_i,
    input  logic                     icd_mosi_i,
    output logic                     cphi2_o,
    output logic                     icd_miso_o,
    output logic                     icd_miso_oe_o
);

    logic run_cpu;      // from icd control byte
    logic trace_en;
    logic setup_cs;
    logic release_wr;

    trace_buf_if i_trace_buf ();
    icd_byte_if  i_icd_byte ();

    cpu_phaser i_cpu_phaser (
        .clk6x        (clk6x),
        .reset_i      (reset_i),
        .run_i        (run_cpu),
        .cphi2_o      (cphi2_o),
        .setup_cs_o   (setup_cs),
        .release_wr_o (release_wr),
        .stopped_o    ()
    );

    bus_trace_sampler i_bus_trace_sampler (
        .clk6x        (clk6x),
        .reset_i      (reset_i),
        .cpu_ab_i     (cpu_ab_i),
        .cpu_db_i     (cpu_db_i),
        .cpu_status_i (cpu_status_i),
        .setup_cs_i   (setup_cs),
        .release_wr_i (release_wr),
        .trace_en_i   (trace_en),
        .buf_o        (i_trace_buf.push_mp)
    );

    trace_fifo i_trace_fifo (
        .clk6x   (clk6x),
        .reset_i (reset_i),
        .buf_io  (i_trace_buf.fifo_mp)
    );

    icd_spi_slave i_icd_spi_slave (
        .clk6x     (clk6x),
        .reset_i   (reset_i),
        .sck_i     (icd_sck_i),
        .csn_i     (icd_csn_i),
        .mosi_i    (icd_mosi_i),
        .miso_o    (icd_miso_o),
        .miso_oe_o (icd_miso_oe_o),
        .byte_o    (i_icd_byte.slave_mp)
    );

    icd_trace_reader i_icd_trace_reader (
        .clk6x      (clk6x),
        .reset_i    (reset_i),
        .byte_i     (i_icd_byte.reader_mp),
        .buf_i      (i_trace_buf.pop_mp),
        .run_cpu_o  (run_cpu),
        .trace_en_o (trace_en)
    );

endmodule

// ==== icd_trace_reader.sv ====
`timescale 1ns/1ps
// icd command decoder for status, trace readout and cpu control
// one record per READ_TRACE frame, bytes past it read as idle
module icd_trace_reader (
    input  logic          clk6x,
    input  logic          reset_i,
    icd_byte_if.reader_mp byte_i,
    trace_buf_if.pop_mp   buf_i,
    output logic          run_cpu_o,
    output logic          trace_en_o
);
    import icd_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,    // no command or done, answers idle
        ST_CTRL,    // flag byte expected
        ST_TRACE    // record bytes left to send
    } state_t;

    state_t                 state;
    logic [REC_BYTES*8-1:0] rec_sr;     // msb byte is the one on the wire
    logic [1:0]             byte_idx;   // record bytes still to load
    icd_status_t            status;
    logic [7:0]             tx_byte_r;
    logic                   tx_load_r;
    logic                   pop_r;
    logic                   clr_ovf_r;
    logic                   run_r;
    logic                   trace_r;

    assign status = '{overflow: buf_i.overflow, empty: buf_i.empty, full: buf_i.full,
                      zero: 1'b0, level: buf_i.level};

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            state     <= ST_IDLE;
            byte_idx  <= '0;
            tx_load_r <= 1'b0;
            pop_r     <= 1'b0;
            clr_ovf_r <= 1'b0;
            run_r     <= 1'b0;
            trace_r   <= 1'b0;
        end
        else
        begin
            tx_load_r <= 1'b0;      // one-cycle pulses
            pop_r     <= 1'b0;
            clr_ovf_r <= 1'b0;
            if (byte_i.rx_hdr)
            begin
                state <= ST_IDLE;
                case (byte_i.rx_byte)
                    CMD_STATUS:
                    begin
                        tx_byte_r <= status;
                        tx_load_r <= 1'b1;
                    end
                    CMD_READ_TRACE:
                    begin
                        if (!buf_i.empty)
                        begin
                            rec_sr    <= buf_i.head_rec;  // taken before the pop lands
                            tx_byte_r <= buf_i.head_rec[REC_BYTES*8-1 -: 8];
                            tx_load_r <= 1'b1;
                            pop_r     <= 1'b1;
                            byte_idx  <= 2'(REC_BYTES - 1);
                            state     <= ST_TRACE;
                        end
                    end
                    CMD_CONTROL: state <= ST_CTRL;
                    default:     state <= ST_IDLE;  // unknown, idle bytes only
                endcase
            end
            else if (byte_i.rx_db)
            begin
                case (state)
                    ST_CTRL:
                    begin
                        run_r     <= byte_i.rx_byte[CTRL_RUN_BIT];
                        trace_r   <= byte_i.rx_byte[CTRL_TRACE_BIT];
                        clr_ovf_r <= byte_i.rx_byte[CTRL_CLR_OVF_BIT];
                        state     <= ST_IDLE;
                    end
                    ST_TRACE:
                    begin
                        rec_sr    <= rec_sr << 8;
                        tx_byte_r <= rec_sr[REC_BYTES*8-9 -: 8];
                        tx_load_r <= 1'b1;
                        byte_idx  <= byte_idx - 2'd1;
                        if (byte_idx == 2'd1)
                            state <= ST_IDLE;   // last record byte loaded
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    assign byte_i.tx_byte = tx_byte_r;
    assign byte_i.tx_load = tx_load_r;
    assign buf_i.pop      = pop_r;
    assign buf_i.clr_ovf  = clr_ovf_r;
    assign run_cpu_o      = run_r;
    assign trace_en_o     = trace_r;

endmodule

// ==== icd_spi_slave.sv ====
`timescale 1ns/1ps
// icd spi target, mode 0, msb first; pins pass a two-flop sync
// sck high and low times must each be at least 4 clk6x
module icd_spi_slave (
    input  logic         clk6x,
    input  logic         reset_i,
    input  logic         sck_i,
    input  logic         csn_i,
    input  logic         mosi_i,
    output logic         miso_o,
    output logic         miso_oe_o,
    icd_byte_if.slave_mp byte_o
);
    import icd_pkg::*;

    logic [1:0] sck_s;
    logic [1:0] csn_s;
    logic [1:0] mosi_s;
    logic       sck_d;      // previous synced sck
    logic       sck_rise;
    logic       sck_fall;
    logic       active;
    logic [2:0] bit_cnt;
    logic [6:0] rx_sr;      // bits so far
    logic [7:0] tx_sr;      // msb is on miso
    logic [7:0] tx_next;    // byte for the next slot
    logic       first_r;    // next full byte is the header
    logic [7:0] rx_byte_r;
    logic       rx_hdr_r;
    logic       rx_db_r;

    assign active   = !csn_s[1];
    assign sck_rise = active && sck_s[1] && !sck_d;
    assign sck_fall = active && !sck_s[1] && sck_d;

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            sck_s  <= '0;
            csn_s  <= '1;
            mosi_s <= '0;
            sck_d  <= 1'b0;
        end
        else
        begin
            sck_s  <= {sck_s[0], sck_i};
            csn_s  <= {csn_s[0], csn_i};
            mosi_s <= {mosi_s[0], mosi_i};
            sck_d  <= sck_s[1];
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (sck_rise)
        begin
            rx_sr <= {rx_sr[5:0], mosi_s[1]};
            if (bit_cnt == 3'd7)
                rx_byte_r <= {rx_sr, mosi_s[1]};
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            bit_cnt  <= '0;
            first_r  <= 1'b1;
            tx_sr    <= IDLE_BYTE;
            tx_next  <= IDLE_BYTE;
            rx_hdr_r <= 1'b0;
            rx_db_r  <= 1'b0;
        end
        else
        begin
            rx_hdr_r <= 1'b0;
            rx_db_r  <= 1'b0;
            if (!active)
            begin
                bit_cnt <= '0;
                first_r <= 1'b1;
                tx_sr   <= IDLE_BYTE;     // header slot always idle
                tx_next <= IDLE_BYTE;
            end
            else
            begin
                if (byte_o.tx_load)
                    tx_next <= byte_o.tx_byte;
                if (sck_rise)
                begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7)
                    begin
                        rx_hdr_r <= first_r;
                        rx_db_r  <= !first_r;
                        first_r  <= 1'b0;
                    end
                end
                if (sck_fall)
                begin
                    if (bit_cnt == '0)
                    begin
                        tx_sr   <= tx_next;   // byte boundary
                        tx_next <= IDLE_BYTE; // unless reloaded
                    end
                    else
                        tx_sr <= {tx_sr[6:0], 1'b1};
                end
            end
        end
    end

    assign miso_o         = tx_sr[7];
    assign miso_oe_o      = active;
    assign byte_o.rx_byte = rx_byte_r;
    assign byte_o.rx_hdr  = rx_hdr_r;
    assign byte_o.rx_db   = rx_db_r;

endmodule

// ==== trace_fifo.sv ====
`timescale 1ns/1ps
// fall-through buffer of TRACE_DEPTH entries, depth a power of two
// no back-pressure, so a push while full is lost and flagged
module trace_fifo #(
    parameter type item_t = cpu_bus_pkg::trace_rec_t
) (
    input  logic         clk6x,
    input  logic         reset_i,
    trace_buf_if.fifo_mp buf_io
);
    import icd_pkg::*;

    item_t                  mem [TRACE_DEPTH];
    logic [TRACE_PTR_W-1:0] wr_ptr;     // wraps naturally
    logic [TRACE_PTR_W-1:0] rd_ptr;
    level_t                 level_r;
    logic                   ovf_r;
    logic                   full;
    logic                   empty;
    logic                   do_push;
    logic                   do_pop;

    assign full    = (level_r == level_t'(TRACE_DEPTH));
    assign empty   = (level_r == '0);
    assign do_push = buf_io.push && !full;
    assign do_pop  = buf_io.pop && !empty;

    always_ff @(posedge clk6x)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= buf_io.push_rec;
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level_r <= '0;
            ovf_r   <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   level_r <= level_r + 4'd1;
                2'b01:   level_r <= level_r - 4'd1;
                default: level_r <= level_r;   // none, or both at once
            endcase
            if (buf_io.push && full)
                ovf_r <= 1'b1;      // a lost record wins over clear
            else if (buf_io.clr_ovf)
                ovf_r <= 1'b0;
        end
    end

    assign buf_io.head_rec = mem[rd_ptr];
    assign buf_io.empty    = empty;
    assign buf_io.full     = full;
    assign buf_io.level    = level_r;
    assign buf_io.overflow = ovf_r;

endmodule

// ==== bus_trace_sampler.sv ====
`timescale 1ns/1ps
// one trace record per cpu cycle, pushed a clk6x after release_wr
// write data must be valid on the data bus by release_wr
module bus_trace_sampler (
    input  logic                     clk6x,
    input  logic                     reset_i,
    input  cpu_bus_pkg::cpu_addr_t   cpu_ab_i,
    input  cpu_bus_pkg::cpu_data_t   cpu_db_i,
    input  cpu_bus_pkg::cpu_status_t cpu_status_i,
    input  logic                     setup_cs_i,
    input  logic                     release_wr_i,
    input  logic                     trace_en_i,
    trace_buf_if.push_mp             buf_o
);
    import cpu_bus_pkg::*;

    cpu_addr_t   addr_r;
    cpu_status_t status_r;
    cpu_data_t   data_r;
    trace_rec_t  rec;
    logic        push_r;

    always_ff @(posedge clk6x)
    begin
        if (setup_cs_i)
        begin
            addr_r   <= cpu_ab_i;       // address stable after phi2 fall
            status_r <= cpu_status_i;
        end
        if (release_wr_i)
        begin
            data_r <= cpu_db_i;         // read or write data, end of phi2 high
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            push_r <= 1'b0;
        end
        else
        begin
            push_r <= release_wr_i && trace_en_i;
        end
    end

    assign rec = '{addr: addr_r, data: data_r, status: status_r};

    assign buf_o.push     = push_r;
    assign buf_o.push_rec = rec;

endmodule

// ==== cpu_phaser.sv ====
`timescale 1ns/1ps
// cpu clock from clk6x, 3 low + 3 high; run is sampled only at cycle end
// stopping always completes the cycle in progress
module cpu_phaser (
    input  logic clk6x,
    input  logic reset_i,
    input  logic run_i,
    output logic cphi2_o,
    output logic setup_cs_o,
    output logic release_wr_o,
    output logic stopped_o
);
    import cpu_bus_pkg::*;

    phase_t phase_r;
    phase_t phase_nxt;
    logic   run_r;          // run as taken at the last boundary
    logic   cphi2_r;
    logic   cyc_end;

    assign cyc_end = (phase_r == phase_t'(PHASE_COUNT - 1));

    always_comb
    begin
        phase_nxt = phase_r;    // hold phase 0 while stopped
        if (run_r)
        begin
            phase_nxt = cyc_end ? '0 : phase_r + 3'd1;
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            phase_r <= '0;
            run_r   <= 1'b0;
            cphi2_r <= 1'b0;
        end
        else
        begin
            phase_r <= phase_nxt;
            if (cyc_end || !run_r)
            begin
                run_r <= run_i;     // boundary only
            end
            cphi2_r <= run_r && (phase_nxt >= PH_CPHI2_HIGH);  // aligned with phase_r
        end
    end

    // strobes decode the phase, phase is 0 whenever stopped
    assign setup_cs_o   = (phase_r == PH_SETUP);
    assign release_wr_o = (phase_r == PH_RELEASE_WR);
    assign cphi2_o      = cphi2_r;
    assign stopped_o    = !run_r;

endmodule

// ==== icd_byte_if.sv ====
`timescale 1ns/1ps
// byte exchange between icd spi slave and command reader
// tx_load must follow its rx pulse within 3 clk6x
interface icd_byte_if;

    logic [7:0] rx_byte;
    logic       rx_hdr;     // first byte after csn fall
    logic       rx_db;      // every later byte
    logic [7:0] tx_byte;
    logic       tx_load;    // latch tx_byte for the next byte out

    modport slave_mp (output rx_byte, output rx_hdr, output rx_db,
                      input tx_byte, input tx_load);
    modport reader_mp (input rx_byte, input rx_hdr, input rx_db,
                       output tx_byte, output tx_load);

endinterface

// ==== trace_buf_if.sv ====
`timescale 1ns/1ps
// record path between sampler, fifo and icd reader
// a push into a full fifo is dropped, never stalled
interface trace_buf_if #(
    parameter type item_t = cpu_bus_pkg::trace_rec_t
);
    import icd_pkg::*;

    logic   push;       // one record per pulse
    item_t  push_rec;
    logic   pop;        // ignored while empty
    logic   clr_ovf;    // clears sticky overflow
    item_t  head_rec;   // oldest entry, fall-through
    logic   empty;
    logic   full;
    level_t level;
    logic   overflow;

    modport push_mp (output push, output push_rec);
    modport pop_mp (output pop, output clr_ovf,
                    input head_rec, input empty, input full, input level, input overflow);
    modport fifo_mp (input push, input push_rec, input pop, input clr_ovf,
                     output head_rec, output empty, output full, output level,
                     output overflow);

endinterface

// ==== icd_pkg.sv ====
// icd command set and trace buffer sizing
// status byte layout is what the debug host decodes
package icd_pkg;

    localparam logic [7:0] CMD_STATUS     = 8'h10;
    localparam logic [7:0] CMD_READ_TRACE = 8'h20;
    localparam logic [7:0] CMD_CONTROL    = 8'h30;

    // control byte flags
    localparam int CTRL_RUN_BIT     = 0;
    localparam int CTRL_TRACE_BIT   = 1;
    localparam int CTRL_CLR_OVF_BIT = 2;

    localparam logic [7:0] IDLE_BYTE = 8'hFF;   // sent when nothing was loaded

    localparam int TRACE_DEPTH = 8;             // records, power of two
    localparam int TRACE_PTR_W = $clog2(TRACE_DEPTH);
    localparam int REC_BYTES   = 4;             // bytes per record on spi

    typedef logic [3:0] level_t;    // 0 .. TRACE_DEPTH

    typedef struct packed {
        logic   overflow;   // sticky
        logic   empty;
        logic   full;
        logic   zero;       // reads 0
        level_t level;
    } icd_status_t;

endpackage

// ==== cpu_bus_pkg.sv ====
// cpu side of the trace path; 65xx bus with a 16-bit address only
// record layout is fixed at 32 bits, the icd readout depends on it
package cpu_bus_pkg;

    localparam int CPU_AW = 16;     // address bus
    localparam int CPU_DW = 8;      // data bus

    typedef logic [CPU_AW-1:0] cpu_addr_t;
    typedef logic [CPU_DW-1:0] cpu_data_t;

    // status pins as seen at setup time
    typedef struct packed {
        logic sync_vpa;     // sync (8b) / vpa (16b)
        logic mlock;        // memory lock
        logic vpull;        // vector pull
        logic vda;          // 16b only
        logic ef;           // 16b only
        logic sob_mx;       // sob (8b) / mx (16b)
        logic rdy;
        logic rwn;          // 1 = read
    } cpu_status_t;

    localparam int PHASE_COUNT = 6;     // clk6x per cpu cycle
    typedef logic [2:0] phase_t;

    localparam phase_t PH_SETUP      = 3'd2;    // address valid, setup_cs
    localparam phase_t PH_CPHI2_HIGH = 3'd3;    // first phase with cphi2 high
    localparam phase_t PH_RELEASE_WR = 3'd4;    // write data valid

    typedef struct packed {
        cpu_addr_t   addr;
        cpu_data_t   data;
        cpu_status_t status;
    } trace_rec_t;

endpackage
